/* design/bru_params.svh */
// --------------------------------------------------------------------------
// Widths and port counts of the branch resolve pipeline.
// Register data and addresses share one word, there is no separate VA width.
// Compressed instructions are not supported, so the sequential step is fixed.
// --------------------------------------------------------------------------
`ifndef BRU_PARAMS_SVH
`define BRU_PARAMS_SVH

// Register data and program counter width
`define BRU_XLEN 32

// Physical register tag, tag 0 maps to x0
`define BRU_TAG_W 6

`define BRU_WB_PORTS 2 // Write-back buses sampled in EX1

`define BRU_INST_W 32

// Next-sequential pc increment
`define BRU_PC_STEP 4

`endif

/* design/bru_pkg.sv */
// --------------------------------------------------------------------------
// Types shared by the branch resolve pipeline.
// Decode codes are the only enums since the pipeline has no FSM.
// --------------------------------------------------------------------------
`default_nettype none

`include "bru_params.svh"

package bru_pkg;

  // ------------------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------------------
  typedef logic [`BRU_XLEN-1:0]   xlen_t;   // Register data
  typedef logic [`BRU_XLEN-1:0]   vaddr_t;  // Pc or target
  typedef logic [`BRU_TAG_W-1:0]  rtag_t;   // Tag 0 reads as zero
  typedef logic [`BRU_INST_W-1:0] inst_t;

  // ------------------------------------------------------------------------
  // Decode codes
  // ------------------------------------------------------------------------
  typedef enum logic [2:0] {
    OP_EQ,
    OP_NE,
    OP_LT,    // Signed
    OP_GE,    // Signed
    OP_LTU,
    OP_GEU,
    OP_JUMP,  // JAL and JALR
    OP_NONE
  } br_op_e;

  typedef enum logic [1:0] {
    IMM_SB,   // Conditional offset
    IMM_UJ,   // JAL offset
    IMM_I,    // JALR, rs1 plus offset
    IMM_NONE
  } imm_kind_e;

endpackage

`default_nettype wire

/* design/bru_ex2_if.sv */
// --------------------------------------------------------------------------
// EX2 item from the stage registers to the resolver.
// No handshake, a valid item is consumed at the next clock edge.
// dead already includes a flush seen during EX2.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface bru_ex2_if;

  logic                  valid;
  logic                  dead;
  bru_pkg::br_op_e       op;
  bru_pkg::imm_kind_e    imm_kind;
  logic                  wr_rd;        // JAL/JALR link
  bru_pkg::inst_t        inst;         // Immediates come from here
  bru_pkg::vaddr_t       pc;
  bru_pkg::xlen_t        rs1_data;
  bru_pkg::xlen_t        rs2_data;
  bru_pkg::rtag_t        rd_tag;
  logic                  pred_taken;
  bru_pkg::vaddr_t       pred_target;

  modport stage (
    output valid, dead, op, imm_kind, wr_rd, inst, pc,
           rs1_data, rs2_data, rd_tag, pred_taken, pred_target
  );

  modport resolve (
    input valid, dead, op, imm_kind, wr_rd, inst, pc,
          rs1_data, rs2_data, rd_tag, pred_taken, pred_target
  );

endinterface

`default_nettype wire

/* design/bru_decode.sv */
// --------------------------------------------------------------------------
// EX0 branch decoder, purely combinational.
// Only RV32 BRANCH, JAL and JALR are recognized, no compressed forms.
// Anything else decodes to OP_NONE with no link write.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bru_decode (
  input  bru_pkg::inst_t     i_inst,
  output bru_pkg::br_op_e    o_op,
  output bru_pkg::imm_kind_e o_imm_kind,
  output logic               o_is_cond,
  output logic               o_wr_rd
);

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];

  always_comb begin
    o_op       = bru_pkg::OP_NONE;
    o_imm_kind = bru_pkg::IMM_NONE;
    o_is_cond  = 1'b0;
    o_wr_rd    = 1'b0;
    case (w_opcode)
      OPC_BRANCH: begin
        case (w_funct3)
          3'b000:  o_op = bru_pkg::OP_EQ;
          3'b001:  o_op = bru_pkg::OP_NE;
          3'b100:  o_op = bru_pkg::OP_LT;
          3'b101:  o_op = bru_pkg::OP_GE;
          3'b110:  o_op = bru_pkg::OP_LTU;
          3'b111:  o_op = bru_pkg::OP_GEU;
          default: o_op = bru_pkg::OP_NONE;  // 010/011 reserved
        endcase
        if (o_op != bru_pkg::OP_NONE) begin
          o_imm_kind = bru_pkg::IMM_SB;
          o_is_cond  = 1'b1;
        end
      end
      OPC_JAL: begin
        o_op       = bru_pkg::OP_JUMP;
        o_imm_kind = bru_pkg::IMM_UJ;
        o_wr_rd    = 1'b1;
      end
      OPC_JALR: begin
        if (w_funct3 == 3'b000) begin
          o_op       = bru_pkg::OP_JUMP;
          o_imm_kind = bru_pkg::IMM_I;
          o_wr_rd    = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* design/bru_operand_fwd.sv */
// --------------------------------------------------------------------------
// EX1 operand select for one source register, combinational.
// Matching write-back entries are assumed one-hot, they are OR-ed together.
// Tag 0 is x0 and always gives zero.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "bru_params.svh"

module bru_operand_fwd (
  input  bru_pkg::rtag_t                      i_tag,
  input  bru_pkg::xlen_t                      i_read_data,
  input  logic [`BRU_WB_PORTS-1:0]            i_wb_valid,
  input  bru_pkg::rtag_t [`BRU_WB_PORTS-1:0]  i_wb_tag,
  input  bru_pkg::xlen_t [`BRU_WB_PORTS-1:0]  i_wb_data,
  output bru_pkg::xlen_t                      o_data
);

  logic [`BRU_WB_PORTS-1:0] w_hit;
  bru_pkg::xlen_t           w_fwd_data;
  logic                     w_is_x0;

  assign w_is_x0 = (i_tag == '0);

  // One-hot OR over the write-back buses
  always_comb begin
    w_hit      = '0;
    w_fwd_data = '0;
    for (int i = 0; i < `BRU_WB_PORTS; i++) begin
      w_hit[i]   = i_wb_valid[i] & (i_wb_tag[i] == i_tag) & ~w_is_x0;
      w_fwd_data = w_fwd_data | ({`BRU_XLEN{w_hit[i]}} & i_wb_data[i]);
    end
  end

  always_comb begin
    if (w_is_x0) begin
      o_data = '0;
    end else if (|w_hit) begin
      o_data = w_fwd_data;
    end else begin
      o_data = i_read_data;  // Register file
    end
  end

endmodule

`default_nettype wire

/* design/bru_resolve.sv */
// --------------------------------------------------------------------------
// EX2 compare and target logic, registered into the EX3 result outputs.
// Results carry no handshake and must be taken when o_br_valid is high.
// A dead item still reports o_br_valid but never writes its link register.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "bru_params.svh"

module bru_resolve (
  input  logic              i_clk,
  input  logic              i_reset_n,
  bru_ex2_if.resolve        ex2,
  output logic              o_br_valid,
  output bru_pkg::vaddr_t   o_br_pc,
  output logic              o_br_taken,
  output bru_pkg::vaddr_t   o_br_target,
  output logic              o_br_mispredict,
  output logic              o_br_dead,
  output logic              o_wr_valid,
  output bru_pkg::rtag_t    o_wr_tag,
  output bru_pkg::xlen_t    o_wr_data
);

  bru_pkg::vaddr_t w_imm_sb;
  bru_pkg::vaddr_t w_imm_uj;
  bru_pkg::vaddr_t w_imm_i;
  bru_pkg::vaddr_t w_seq_pc;
  bru_pkg::vaddr_t w_jalr_sum;
  bru_pkg::vaddr_t w_jump_target;
  bru_pkg::vaddr_t w_target;
  logic            w_taken;
  logic            w_mispredict;
  logic            w_wr_valid;

  // ------------------------------------------------------------------------
  // EX2: immediates
  // ------------------------------------------------------------------------
  assign w_imm_sb = {{(`BRU_XLEN-13){ex2.inst[31]}}, ex2.inst[31], ex2.inst[7],
                     ex2.inst[30:25], ex2.inst[11:8], 1'b0};
  assign w_imm_uj = {{(`BRU_XLEN-21){ex2.inst[31]}}, ex2.inst[31], ex2.inst[19:12],
                     ex2.inst[20], ex2.inst[30:21], 1'b0};
  assign w_imm_i  = {{(`BRU_XLEN-12){ex2.inst[31]}}, ex2.inst[31:20]};

  assign w_seq_pc   = ex2.pc + bru_pkg::vaddr_t'(`BRU_PC_STEP);
  assign w_jalr_sum = ex2.rs1_data + w_imm_i;

  // ------------------------------------------------------------------------
  // EX2: direction and target
  // ------------------------------------------------------------------------
  always_comb begin
    case (ex2.op)
      bru_pkg::OP_EQ:   w_taken = (ex2.rs1_data == ex2.rs2_data);
      bru_pkg::OP_NE:   w_taken = (ex2.rs1_data != ex2.rs2_data);
      bru_pkg::OP_LT:   w_taken = ($signed(ex2.rs1_data) < $signed(ex2.rs2_data));
      bru_pkg::OP_GE:   w_taken = ($signed(ex2.rs1_data) >= $signed(ex2.rs2_data));
      bru_pkg::OP_LTU:  w_taken = (ex2.rs1_data < ex2.rs2_data);
      bru_pkg::OP_GEU:  w_taken = (ex2.rs1_data >= ex2.rs2_data);
      bru_pkg::OP_JUMP: w_taken = 1'b1;
      default:          w_taken = 1'b0;  // Not a branch
    endcase
  end

  always_comb begin
    case (ex2.imm_kind)
      bru_pkg::IMM_SB: w_jump_target = ex2.pc + w_imm_sb;
      bru_pkg::IMM_UJ: w_jump_target = ex2.pc + w_imm_uj;
      bru_pkg::IMM_I:  w_jump_target = {w_jalr_sum[`BRU_XLEN-1:1], 1'b0};
      default:         w_jump_target = w_seq_pc;
    endcase
  end

  assign w_target = w_taken ? w_jump_target : w_seq_pc;

  // Wrong direction, or right direction but wrong target
  assign w_mispredict = (w_taken != ex2.pred_taken) |
                        (w_taken & (w_target != ex2.pred_target));

  assign w_wr_valid = ex2.valid & ex2.wr_rd & (ex2.rd_tag != '0) & ~ex2.dead;

  // ------------------------------------------------------------------------
  // EX3 result registers
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_br_valid <= 1'b0;
      o_wr_valid <= 1'b0;
    end else begin
      o_br_valid <= ex2.valid;
      o_wr_valid <= w_wr_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_br_pc         <= ex2.pc;
    o_br_taken      <= w_taken;
    o_br_target     <= w_target;
    o_br_mispredict <= w_mispredict;
    o_br_dead       <= ex2.dead;
    o_wr_tag        <= ex2.rd_tag;
    o_wr_data       <= w_seq_pc;  // Link address
  end

endmodule

`default_nettype wire

/* design/bru_pipe.sv */
// --------------------------------------------------------------------------
// Branch resolve pipeline top, EX0 decode through EX3 result.
// Fixed latency of 3 cycles from issue to result, no stall, no back-pressure.
// Register file must answer the EX1 read request in the same cycle.
// A level on i_flush kills every item in EX0 to EX2.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "bru_params.svh"

module bru_pipe (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  // Issue
  input  logic                                i_issue_valid,
  input  bru_pkg::inst_t                      i_issue_inst,
  input  bru_pkg::vaddr_t                     i_issue_pc,
  input  bru_pkg::rtag_t                      i_issue_rs1_tag,
  input  bru_pkg::rtag_t                      i_issue_rs2_tag,
  input  bru_pkg::rtag_t                      i_issue_rd_tag,
  input  logic                                i_issue_pred_taken,
  input  bru_pkg::vaddr_t                     i_issue_pred_target,
  // Register read
  output logic                                o_rs1_read_valid,
  output bru_pkg::rtag_t                      o_rs1_read_tag,
  output logic                                o_rs2_read_valid,
  output bru_pkg::rtag_t                      o_rs2_read_tag,
  input  bru_pkg::xlen_t                      i_rs1_read_data,
  input  bru_pkg::xlen_t                      i_rs2_read_data,
  // Write-back buses
  input  logic [`BRU_WB_PORTS-1:0]            i_wb_valid,
  input  bru_pkg::rtag_t [`BRU_WB_PORTS-1:0]  i_wb_tag,
  input  bru_pkg::xlen_t [`BRU_WB_PORTS-1:0]  i_wb_data,
  input  logic                                i_flush,
  // Results
  output logic                                o_br_valid,
  output bru_pkg::vaddr_t                     o_br_pc,
  output logic                                o_br_taken,
  output bru_pkg::vaddr_t                     o_br_target,
  output logic                                o_br_mispredict,
  output logic                                o_br_dead,
  output logic                                o_wr_valid,
  output bru_pkg::rtag_t                      o_wr_tag,
  output bru_pkg::xlen_t                      o_wr_data
);

  // EX0
  logic               r_ex0_valid;
  bru_pkg::inst_t     r_ex0_inst;
  bru_pkg::vaddr_t    r_ex0_pc;
  bru_pkg::rtag_t     r_ex0_rs1_tag;
  bru_pkg::rtag_t     r_ex0_rs2_tag;
  bru_pkg::rtag_t     r_ex0_rd_tag;
  logic               r_ex0_pred_taken;
  bru_pkg::vaddr_t    r_ex0_pred_target;
  bru_pkg::br_op_e    w_ex0_op;
  bru_pkg::imm_kind_e w_ex0_imm_kind;
  logic               w_ex0_is_cond;
  logic               w_ex0_wr_rd;
  // EX1
  logic               r_ex1_valid;
  logic               r_ex1_dead;
  bru_pkg::br_op_e    r_ex1_op;
  bru_pkg::imm_kind_e r_ex1_imm_kind;
  logic               r_ex1_is_cond;
  logic               r_ex1_wr_rd;
  bru_pkg::inst_t     r_ex1_inst;
  bru_pkg::vaddr_t    r_ex1_pc;
  bru_pkg::rtag_t     r_ex1_rs1_tag;
  bru_pkg::rtag_t     r_ex1_rs2_tag;
  bru_pkg::rtag_t     r_ex1_rd_tag;
  logic               r_ex1_pred_taken;
  bru_pkg::vaddr_t    r_ex1_pred_target;
  bru_pkg::xlen_t     w_ex1_rs1_data;
  bru_pkg::xlen_t     w_ex1_rs2_data;
  // EX2
  logic               r_ex2_dead;

  bru_ex2_if ex2_if ();

  // ------------------------------------------------------------------------
  // EX0: issue register and decode
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    r_ex0_inst        <= i_issue_inst;
    r_ex0_pc          <= i_issue_pc;
    r_ex0_rs1_tag     <= i_issue_rs1_tag;
    r_ex0_rs2_tag     <= i_issue_rs2_tag;
    r_ex0_rd_tag      <= i_issue_rd_tag;
    r_ex0_pred_taken  <= i_issue_pred_taken;
    r_ex0_pred_target <= i_issue_pred_target;
  end

  bru_decode u_decode (
    .i_inst     (r_ex0_inst),
    .o_op       (w_ex0_op),
    .o_imm_kind (w_ex0_imm_kind),
    .o_is_cond  (w_ex0_is_cond),
    .o_wr_rd    (w_ex0_wr_rd)
  );

  // ------------------------------------------------------------------------
  // EX1: register read and forwarding
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    r_ex1_op          <= w_ex0_op;
    r_ex1_imm_kind    <= w_ex0_imm_kind;
    r_ex1_is_cond     <= w_ex0_is_cond;
    r_ex1_wr_rd       <= w_ex0_wr_rd;
    r_ex1_inst        <= r_ex0_inst;
    r_ex1_pc          <= r_ex0_pc;
    r_ex1_rs1_tag     <= r_ex0_rs1_tag;
    r_ex1_rs2_tag     <= r_ex0_rs2_tag;
    r_ex1_rd_tag      <= r_ex0_rd_tag;
    r_ex1_pred_taken  <= r_ex0_pred_taken;
    r_ex1_pred_target <= r_ex0_pred_target;
  end

  assign o_rs1_read_valid = r_ex1_valid;
  assign o_rs1_read_tag   = r_ex1_rs1_tag;
  assign o_rs2_read_valid = r_ex1_valid;
  assign o_rs2_read_tag   = r_ex1_rs2_tag;

  bru_operand_fwd u_rs1_fwd (
    .i_tag       (r_ex1_rs1_tag),
    .i_read_data (i_rs1_read_data),
    .i_wb_valid  (i_wb_valid),
    .i_wb_tag    (i_wb_tag),
    .i_wb_data   (i_wb_data),
    .o_data      (w_ex1_rs1_data)
  );

  bru_operand_fwd u_rs2_fwd (
    .i_tag       (r_ex1_rs2_tag),
    .i_read_data (i_rs2_read_data),
    .i_wb_valid  (i_wb_valid),
    .i_wb_tag    (i_wb_tag),
    .i_wb_data   (i_wb_data),
    .o_data      (w_ex1_rs2_data)
  );

  // ------------------------------------------------------------------------
  // EX2 stage register, feeds the resolver through ex2_if
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    ex2_if.op          <= r_ex1_op;
    ex2_if.imm_kind    <= r_ex1_imm_kind;
    ex2_if.wr_rd       <= r_ex1_wr_rd;
    ex2_if.inst        <= r_ex1_inst;
    ex2_if.pc          <= r_ex1_pc;
    ex2_if.rs1_data    <= w_ex1_rs1_data;
    ex2_if.rs2_data    <= r_ex1_is_cond ? w_ex1_rs2_data : '0;  // Only compares need rs2
    ex2_if.rd_tag      <= r_ex1_rd_tag;
    ex2_if.pred_taken  <= r_ex1_pred_taken;
    ex2_if.pred_target <= r_ex1_pred_target;
  end

  // Valid and dead chain, flush accumulates per stage
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid  <= 1'b0;
      r_ex1_valid  <= 1'b0;
      r_ex1_dead   <= 1'b0;
      ex2_if.valid <= 1'b0;
      r_ex2_dead   <= 1'b0;
    end else begin
      r_ex0_valid  <= i_issue_valid;
      r_ex1_valid  <= r_ex0_valid;
      r_ex1_dead   <= r_ex0_valid & i_flush;
      ex2_if.valid <= r_ex1_valid;
      r_ex2_dead   <= r_ex1_dead | (r_ex1_valid & i_flush);
    end
  end

  assign ex2_if.dead = r_ex2_dead | (ex2_if.valid & i_flush);

  bru_resolve u_resolve (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .ex2             (ex2_if.resolve),
    .o_br_valid      (o_br_valid),
    .o_br_pc         (o_br_pc),
    .o_br_taken      (o_br_taken),
    .o_br_target     (o_br_target),
    .o_br_mispredict (o_br_mispredict),
    .o_br_dead       (o_br_dead),
    .o_wr_valid      (o_wr_valid),
    .o_wr_tag        (o_wr_tag),
    .o_wr_data       (o_wr_data)
  );

endmodule

`default_nettype wire

/* verification/bru_props.sv */
// --------------------------------------------------------------------------
// Timing and consistency assertions for the branch resolve pipeline.
// Issue sampled at edge N shows up in o_br_valid from edge N+3 onward.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bru_props (
  input logic i_clk,
  input logic i_reset_n,
  input logic i_issue_valid,
  input logic o_rs1_read_valid,
  input logic o_rs2_read_valid,
  input logic o_br_valid,
  input logic o_br_dead,
  input logic o_wr_valid
);

  a_reset_quiet: assert property (@(posedge i_clk)
    !i_reset_n |-> !o_br_valid && !o_wr_valid && !o_rs1_read_valid && !o_rs2_read_valid)
    else $error("outputs active during reset");

  // Sampled values, so the result valid is seen 4 edges after the issue edge
  a_br_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_br_valid == $past(i_issue_valid, 4))
    else $error("o_br_valid latency");

  a_wr_live: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_wr_valid |-> o_br_valid && !o_br_dead)
    else $error("write from a dead or missing result");

  a_read_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_rs1_read_valid == $past(i_issue_valid, 2)) &&
    (o_rs2_read_valid == $past(i_issue_valid, 2)))
    else $error("read request latency");

endmodule

bind bru_pipe bru_props u_props (
  .i_clk            (i_clk),
  .i_reset_n        (i_reset_n),
  .i_issue_valid    (i_issue_valid),
  .o_rs1_read_valid (o_rs1_read_valid),
  .o_rs2_read_valid (o_rs2_read_valid),
  .o_br_valid       (o_br_valid),
  .o_br_dead        (o_br_dead),
  .o_wr_valid       (o_wr_valid)
);

`default_nettype wire

/* verification/bru_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the branch resolve pipeline, random mixed traffic.
// Register file answers with a fixed function of the tag.
// Write-back tags on the two buses are kept distinct in every cycle.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "bru_params.svh"

module bru_tb;

  localparam int N_ITEMS = 600;
  localparam int MAX_CYC = 3000;

  typedef struct packed {
    int              issue_edge;
    int              kind;         // 0-5 compares, 6 JAL, 7 JALR, 8 other
    logic [31:0]     offset;
    bru_pkg::vaddr_t pc;
    bru_pkg::rtag_t  rs1_tag;
    bru_pkg::rtag_t  rs2_tag;
    bru_pkg::rtag_t  rd_tag;
    logic            pred_taken;
    bru_pkg::vaddr_t pred_target;
  } item_t;

  typedef struct packed {
    logic            taken;
    bru_pkg::vaddr_t target;
    logic            mispredict;
    logic            wr_valid;
    bru_pkg::xlen_t  wr_data;
  } exp_t;

  logic i_clk, i_reset_n, i_issue_valid, i_issue_pred_taken, i_flush;
  bru_pkg::inst_t  i_issue_inst;
  bru_pkg::vaddr_t i_issue_pc, i_issue_pred_target;
  bru_pkg::rtag_t  i_issue_rs1_tag, i_issue_rs2_tag, i_issue_rd_tag;
  logic o_rs1_read_valid, o_rs2_read_valid;
  bru_pkg::rtag_t  o_rs1_read_tag, o_rs2_read_tag;
  bru_pkg::xlen_t  i_rs1_read_data, i_rs2_read_data;
  logic [`BRU_WB_PORTS-1:0]           i_wb_valid;
  bru_pkg::rtag_t [`BRU_WB_PORTS-1:0] i_wb_tag;
  bru_pkg::xlen_t [`BRU_WB_PORTS-1:0] i_wb_data;
  logic o_br_valid, o_br_taken, o_br_mispredict, o_br_dead, o_wr_valid;
  bru_pkg::vaddr_t o_br_pc, o_br_target;
  bru_pkg::rtag_t  o_wr_tag;
  bru_pkg::xlen_t  o_wr_data;

  // Per-edge record of what the DUT sampled
  logic                               flush_hist [0:4095];
  logic [`BRU_WB_PORTS-1:0]           wbv_hist [0:4095];
  bru_pkg::rtag_t [`BRU_WB_PORTS-1:0] wbt_hist [0:4095];
  bru_pkg::xlen_t [`BRU_WB_PORTS-1:0] wbd_hist [0:4095];
  item_t                              iss_hist [0:4095];
  logic                               issv_hist [0:4095];

  item_t       pend[$];
  int          edge_cnt = 0;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] lfsr = 32'd56;

  bru_pipe DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  always @(posedge i_clk) edge_cnt <= edge_cnt + 1;

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
      r    = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic bru_pkg::xlen_t rf_value(bru_pkg::rtag_t tag);
    return {tag, tag, tag, tag, tag, 2'b10} ^ 32'h5A5A_0F0F;
  endfunction

  assign i_rs1_read_data = rf_value(o_rs1_read_tag);
  assign i_rs2_read_data = rf_value(o_rs2_read_tag);

  function automatic bru_pkg::xlen_t operand(bru_pkg::rtag_t tag, int e);
    if (tag == '0) return '0;
    for (int p = 0; p < `BRU_WB_PORTS; p++) begin
      if (wbv_hist[e][p] && wbt_hist[e][p] == tag) return wbd_hist[e][p];
    end
    return rf_value(tag);
  endfunction

  // Expected EX3 result from the branch rules
  function automatic exp_t expect_result(item_t it, bru_pkg::xlen_t a, bru_pkg::xlen_t b,
                                         logic dead);
    exp_t e;
    e = '0;
    case (it.kind)
      0: e.taken = (a == b);
      1: e.taken = (a != b);
      2: e.taken = ($signed(a) < $signed(b));
      3: e.taken = ($signed(a) >= $signed(b));
      4: e.taken = (a < b);
      5: e.taken = (a >= b);
      6, 7: e.taken = 1'b1;
      default: e.taken = 1'b0;
    endcase
    if (!e.taken) e.target = it.pc + 32'd4;
    else if (it.kind == 7) e.target = (a + it.offset) & ~32'd1;
    else e.target = it.pc + it.offset;
    e.mispredict = (e.taken != it.pred_taken) || (e.taken && e.target != it.pred_target);
    e.wr_valid   = (it.kind >= 6 && it.kind <= 7) && it.rd_tag != '0 && !dead;
    e.wr_data    = it.pc + 32'd4;
    return e;
  endfunction

  function automatic bru_pkg::inst_t encode(int kind, logic [31:0] off);
    logic [2:0] f3 [0:5];
    f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    if (kind < 6)
      return {off[12], off[10:5], 5'd2, 5'd1, f3[kind], off[4:1], off[11], 7'b1100011};
    if (kind == 6) return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    if (kind == 7) return {off[11:0], 5'd1, 3'b000, 5'd1, 7'b1100111};
    return {12'h123, 5'd1, 3'b000, 5'd1, 7'b0010011};  // ADDI
  endfunction

  function automatic bru_pkg::rtag_t pick_tag();
    logic [31:0] r;
    r = rand_bits(9);
    return (r[8:6] == 3'd0) ? '0 : r[5:0];
  endfunction

  task automatic drive_cycle(logic issue);
    item_t       it;
    item_t       tgt;
    logic [31:0] r;
    int          t;
    @(negedge i_clk);
    t  = edge_cnt + 1;
    r  = rand_bits(4);
    it = '0;
    it.issue_edge = t;
    it.kind = (r < 9) ? int'(r) % 6 : (r < 11) ? 6 : (r < 14) ? 7 : 8;
    r = rand_bits(20);
    if (it.kind < 6) it.offset = {{19{r[11]}}, r[11:0], 1'b0};
    else if (it.kind == 6) it.offset = {{11{r[19]}}, r[19:0], 1'b0};
    else it.offset = {{20{r[11]}}, r[11:0]};
    r = rand_bits(30);
    it.pc          = {r[29:0], 2'b00};
    it.rs1_tag     = pick_tag();
    it.rs2_tag     = pick_tag();
    it.rd_tag      = pick_tag();
    r = rand_bits(2);
    it.pred_taken  = r[0];
    if (r[1]) begin
      it.pred_target = it.pc + it.offset;
    end else begin
      r = rand_bits(30);
      it.pred_target = {r[29:0], 2'b00};
    end
    i_issue_valid       = issue;
    i_issue_inst        = encode(it.kind, it.offset);
    i_issue_pc          = it.pc;
    i_issue_rs1_tag     = it.rs1_tag;
    i_issue_rs2_tag     = it.rs2_tag;
    i_issue_rd_tag      = it.rd_tag;
    i_issue_pred_taken  = it.pred_taken;
    i_issue_pred_target = it.pred_target;
    // Aim write-back entries at the item reaching the end of EX1
    tgt = (t >= 2) ? iss_hist[t-2] : '0;
    for (int p = 0; p < `BRU_WB_PORTS; p++) begin
      r = rand_bits(5);
      i_wb_valid[p] = r[0];
      i_wb_tag[p]   = (r[2:1] == 0) ? tgt.rs1_tag : (r[2:1] == 1) ? tgt.rs2_tag :
                      (r[2:1] == 2) ? pick_tag() : '0;
      case (r[4:3])
        0: i_wb_data[p] = 32'h8000_0000;
        1: i_wb_data[p] = 32'h7FFF_FFFF;
        2: i_wb_data[p] = 32'hFFFF_FFFF;
        default: i_wb_data[p] = rand_bits(32);
      endcase
    end
    if (i_wb_tag[1] == i_wb_tag[0]) i_wb_valid[1] = 1'b0;
    r = rand_bits(5);
    i_flush = (r == 0);
    flush_hist[t] = i_flush;
    wbv_hist[t] = i_wb_valid;
    wbt_hist[t] = i_wb_tag;
    wbd_hist[t] = i_wb_data;
    iss_hist[t] = it;
    issv_hist[t] = issue;
    if (issue) pend.push_back(it);
  endtask

  task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] want);
    errors++;
    $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, want);
  endtask

  // Compare process, outputs are stable at the falling edge
  always @(negedge i_clk) begin
    item_t it;
    exp_t  e;
    logic  dead;
    logic  rd_req;
    int    n;
    if (i_reset_n) begin
      // Read request belongs to the item issued one edge earlier
      rd_req = issv_hist[edge_cnt-1];
      if (o_rs1_read_valid != rd_req)
        report_mismatch("o_rs1_read_valid", 32'(o_rs1_read_valid), 32'(rd_req));
      if (o_rs2_read_valid != rd_req)
        report_mismatch("o_rs2_read_valid", 32'(o_rs2_read_valid), 32'(rd_req));
      if (rd_req && o_rs1_read_tag != iss_hist[edge_cnt-1].rs1_tag)
        report_mismatch("o_rs1_read_tag", 32'(o_rs1_read_tag),
                        32'(iss_hist[edge_cnt-1].rs1_tag));
      if (rd_req && o_rs2_read_tag != iss_hist[edge_cnt-1].rs2_tag)
        report_mismatch("o_rs2_read_tag", 32'(o_rs2_read_tag),
                        32'(iss_hist[edge_cnt-1].rs2_tag));
      if (pend.size() > 0 && pend[0].issue_edge + 3 == edge_cnt) begin
        it   = pend.pop_front();
        n    = it.issue_edge;
        dead = flush_hist[n+1] | flush_hist[n+2] | flush_hist[n+3];
        e    = expect_result(it, operand(it.rs1_tag, n+2), operand(it.rs2_tag, n+2), dead);
        checks++;
        if (!o_br_valid) report_mismatch("o_br_valid", 32'(o_br_valid), 32'd1);
        if (o_br_pc != it.pc) report_mismatch("o_br_pc", o_br_pc, it.pc);
        if (o_br_dead != dead) report_mismatch("o_br_dead", 32'(o_br_dead), 32'(dead));
        if (o_br_taken != e.taken) report_mismatch("o_br_taken", 32'(o_br_taken), 32'(e.taken));
        if (o_br_target != e.target) report_mismatch("o_br_target", o_br_target, e.target);
        if (o_br_mispredict != e.mispredict)
          report_mismatch("o_br_mispredict", 32'(o_br_mispredict), 32'(e.mispredict));
        if (o_wr_valid != e.wr_valid)
          report_mismatch("o_wr_valid", 32'(o_wr_valid), 32'(e.wr_valid));
        if (e.wr_valid && o_wr_tag != it.rd_tag) report_mismatch("o_wr_tag", 32'(o_wr_tag),
                                                                  32'(it.rd_tag));
        if (e.wr_valid && o_wr_data != e.wr_data) report_mismatch("o_wr_data", o_wr_data,
                                                                   e.wr_data);
      end else if (o_br_valid || o_wr_valid) begin
        report_mismatch("unexpected result valid", 32'(o_br_valid), 32'd0);
      end
    end
  end

  always @(posedge i_clk) begin
    if (edge_cnt >= MAX_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    i_reset_n = 1'b0;
    i_issue_valid = 1'b0;
    i_issue_inst = '0;
    i_issue_pc = '0;
    i_issue_rs1_tag = '0;
    i_issue_rs2_tag = '0;
    i_issue_rd_tag = '0;
    i_issue_pred_taken = 1'b0;
    i_issue_pred_target = '0;
    i_wb_valid = '0;
    i_wb_tag = '0;
    i_wb_data = '0;
    i_flush = 1'b0;
    for (int k = 0; k < 4096; k++) begin
      flush_hist[k] = 1'b0;
      wbv_hist[k] = '0;
      iss_hist[k] = '0;
      issv_hist[k] = 1'b0;
    end
    repeat (3) @(negedge i_clk);
    i_reset_n = 1'b1;
    for (int k = 0; k < N_ITEMS; k++) begin
      r = rand_bits(3);
      if (r == 0) drive_cycle(1'b0);  // Bubble
      drive_cycle(1'b1);
    end
    repeat (6) drive_cycle(1'b0);
    $display("Items checked: %0d, errors: %0d, left over: %0d", checks, errors, pend.size());
    if (errors == 0 && pend.size() == 0 && checks == N_ITEMS) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/bru_pkg.sv
design/bru_ex2_if.sv
design/bru_decode.sv
design/bru_operand_fwd.sv
design/bru_resolve.sv
design/bru_pipe.sv
verification/bru_props.sv
verification/bru_tb.sv

/* Makefile */
# Verilator build and run of the branch resolve pipeline testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module bru_tb -Mdir obj_dir
	./obj_dir/Vbru_tb | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Run failed"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "No result line"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
